// File: build.f
verilog/zport_pkg.sv
verilog/zport_bus_sync.sv
verilog/zport_decode.sv
verilog/zport_ide_seq.sv
verilog/zport_paging.sv
verilog/zport_xt_regs.sv
verilog/zport_top.sv
testbench/tb_clkgen.sv
testbench/tb_zports.sv

// File: run.sh
#!/bin/sh
# compile and run the port block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_zports -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_zports)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
exit 1

// File: testbench/tb_clkgen.sv
//////////////////////////////////////////////////////////////////////
// clock and synchronous reset source for the port block testbench
//////////////////////////////////////////////////////////////////////

module tb_clkgen
#(
	parameter int PERIOD     = 4,
	parameter int RST_CYCLES = 5
)
(
	output logic zclk,
	output logic rst_n
);

	initial
	begin
		zclk = 1'b0;
		forever #(PERIOD / 2) zclk = ~zclk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge zclk);
		@(negedge zclk);
		rst_n = 1'b1;    // released between edges
	end

endmodule

// File: testbench/tb_zports.sv
//////////////////////////////////////////////////////////////////////
// testbench for the Z80 I/O port block; runs I/O bus cycles against
// the top level and checks the results with assertions
//////////////////////////////////////////////////////////////////////

module tb_zports import zport_pkg::*;
();

	// index values that must not hit any #nnAF register
	localparam logic [6:0][7:0] BAD_IDX = {8'h00, 8'h14, 8'h22, 8'h24, 8'h26, 8'h30, 8'hFF};

	logic        zclk;
	logic        rst_n;
	logic [7:0]  din;
	zport_addr_u a;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [15:0] idein;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	ide_bus_t    ide;
	page_cfg_t   page;
	xt_cfg_t     xt;

	// what the last bus cycle saw
	logic [7:0]  rd_byte;
	logic        hit_s;
	logic        dout_en_s;
	logic        dev_rd_seen;
	logic        dev_wr_seen;
	logic        drv_seen;
	logic        cs0_seen;
	logic        cs1_seen;
	logic [2:0]  ide_a_s;
	logic [15:0] wdata_s;

	// expected register state
	page_cfg_t   exp_page;
	xt_cfg_t     exp_xt;
	logic [7:0]  eff7_raw;
	logic        exp_lock;

	tb_clkgen #(.PERIOD(4), .RST_CYCLES(5)) u_clkgen (.zclk(zclk), .rst_n(rst_n));

	zport_top #(.NUM_RAMPAGES(4)) uut (.zclk(zclk), .rst_n(rst_n), .din(din), .a(a),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .keys_in(keys_in),
		.tape_read(tape_read), .idein(idein), .dout(dout), .dataout(dataout),
		.porthit(porthit), .ide(ide), .page(page), .xt(xt));

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp)
		else fail_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp)
		else fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////
	// bus side checks, every cycle
	////////////////////////////////////////////////////////////////////

	a_dataout: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout == (porthit && !iorq_n && !rd_n))
		else fail_run($sformatf("Mismatch at %0t: dataout expected %b, got %b", $time,
			porthit && !iorq_n && !rd_n, dataout));

	a_cs1_c8: assert property (@(posedge zclk) disable iff (!rst_n)
		!ide.cs1_n |-> (a.xt.port == 8'hC8))
		else fail_run("ide cs1_n went low for a port other than #C8");

	a_hi_no_dev_wr: assert property (@(posedge zclk) disable iff (!rst_n)
		(!iorq_n && !wr_n && (a.xt.port == 8'h11)) |-> ide.wr_n)
		else fail_run("the IDE device saw a write during a #11 write");

	// entered and left on a falling edge; 4 cycles active, 2 idle
	task automatic bus_cycle(input logic is_wr, input logic [15:0] addr, input logic [7:0] data);
		a           = addr;
		din         = data;
		iorq_n      = 1'b0;
		rd_n        = is_wr;
		wr_n        = !is_wr;
		dev_rd_seen = 1'b0;
		dev_wr_seen = 1'b0;
		drv_seen    = 1'b0;
		cs0_seen    = 1'b0;
		cs1_seen    = 1'b0;
		ide_a_s     = 'x;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge zclk);
			if (!ide.rd_n)
				dev_rd_seen = 1'b1;
			if (!ide.cs0_n)
				cs0_seen = 1'b1;
			if (!ide.cs1_n)
				cs1_seen = 1'b1;
			if (!ide.cs0_n || !ide.cs1_n)
				ide_a_s = ide.a;
			if (ide.dataout)
				drv_seen = 1'b1;
			if (!ide.wr_n)
			begin
				dev_wr_seen = 1'b1;
				wdata_s     = ide.wdata;
			end
		end
		rd_byte   = dout;
		hit_s     = porthit;
		dout_en_s = dataout;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		repeat (2) @(negedge zclk);
	endtask

	task automatic io_read(input logic [15:0] addr);
		bus_cycle(1'b0, addr, 8'hFF);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(1'b1, addr, data);
	endtask

	////////////////////////////////////////////////////////////////////
	// register writes with their expected effect
	////////////////////////////////////////////////////////////////////

	task automatic write_7ffd(input logic [7:0] d);
		logic next_lock;
		if (!exp_lock)
		begin
			next_lock         = exp_page.p7ffd[5] & eff7_raw[2];
			exp_page.p7ffd    = d;
			exp_page.page     = eff7_raw[2] ? {3'b000, d[2:0]} : {d[5], d[7:6], d[2:0]};
			exp_page.rom      = d[4];
			exp_lock          = next_lock;
		end
		io_write({1'b0, 7'($urandom), 8'hFD}, d);    // a15 low
	endtask

	task automatic write_eff7(input logic [7:0] d);
		eff7_raw          = d;
		exp_page.peff7    = d[2] ? (d & 8'hB1) : d;
		exp_page.mem1m_on = ~d[2];
		exp_page.ram0_0   = d[3];
		io_write(16'hEFF7, d);
	endtask

	task automatic xt_write(input logic [7:0] idx, input logic [7:0] d);
		case (idx)
			8'h20:                      exp_xt.sysconf = d;
			8'h21:                      exp_xt.memconf = d;
			8'h25:                      exp_xt.im2vect = d;
			8'h10, 8'h11, 8'h12, 8'h13: exp_xt.rampage[idx[1:0]] = d;
			default:                    ;    // no register there
		endcase
		io_write({idx, 8'hAF}, d);
	endtask

	task automatic check_config;
		check_byte("page.page", {2'b00, exp_page.page}, {2'b00, page.page});
		check_bit("page.rom", exp_page.rom, page.rom);
		check_bit("page.mem1m_on", exp_page.mem1m_on, page.mem1m_on);
		check_bit("page.ram0_0", exp_page.ram0_0, page.ram0_0);
		check_byte("page.peff7", exp_page.peff7, page.peff7);
		check_byte("page.p7ffd", exp_page.p7ffd, page.p7ffd);
		check_byte("xt.sysconf", exp_xt.sysconf, xt.sysconf);
		check_byte("xt.memconf", exp_xt.memconf, xt.memconf);
		check_byte("xt.im2vect", exp_xt.im2vect, xt.im2vect);
		for (int i = 0; i < DEF_RAMPAGES; i++)
			check_byte($sformatf("xt.rampage[%0d]", i), exp_xt.rampage[i], xt.rampage[i]);
	endtask

	initial
	begin
		for (int c = 0; c < 5000; c++)
			@(posedge zclk);
		fail_run("the run did not finish within 5000 clock cycles");
	end

	initial
	begin
		int          wait_cnt;
		logic [7:0]  d;
		logic [7:0]  d2;
		logic [7:0]  idx;
		logic [15:0] w;
		din       = 8'h00;
		a         = 16'h0000;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		keys_in   = 5'd0;
		tape_read = 1'b0;
		idein     = 16'h0000;
		void'($urandom(32'ha314_89e0));
		exp_page  = '{page: 6'd0, rom: 1'b0, mem1m_on: 1'b1, ram0_0: 1'b0,
		              peff7: 8'h00, p7ffd: 8'h00};
		exp_xt    = '{sysconf: 8'h00, memconf: 8'h00, im2vect: 8'hFF,
		              rampage: {8'h00, 8'h02, 8'h05, 8'h00}};
		eff7_raw  = 8'h00;
		exp_lock  = 1'b0;

		wait_cnt = 0;
		while ((rst_n !== 1'b1) && (wait_cnt < 20))
		begin
			@(negedge zclk);
			wait_cnt++;
		end
		if (rst_n !== 1'b1)
			fail_run("reset was never released");
		@(negedge zclk);

		// reset state and config read-back
		check_config();
		io_read(16'h0ABE);
		check_byte("dout #0ABE", 8'h00, rd_byte);
		io_read(16'h0BBE);
		check_byte("dout #0BBE", 8'h00, rd_byte);

		// keyboard port and an unused one
		for (int i = 0; i < 8; i++)
		begin
			keys_in   = 5'($urandom);
			tape_read = 1'($urandom);
			io_read({8'($urandom), 8'hFE});
			check_byte("dout #FE", {1'b1, tape_read, 1'b0, keys_in}, rd_byte);
			check_bit("porthit #FE", 1'b1, hit_s);
			check_bit("dataout #FE", 1'b1, dout_en_s);
		end
		io_read(16'h0033);
		check_byte("dout #33", 8'hFF, rd_byte);
		check_bit("porthit #33", 1'b0, hit_s);

		////////////////////////////////////////////////////////////////
		// paging
		////////////////////////////////////////////////////////////////

		for (int i = 0; i < 8; i++)
		begin
			write_7ffd(8'($urandom));
			check_config();
			io_read(16'h0ABE);
			check_byte("dout #0ABE", exp_page.p7ffd, rd_byte);
		end
		write_7ffd(8'h00);
		write_eff7(8'($urandom) | 8'h04);    // block1m on
		check_config();
		io_read(16'h0BBE);
		check_byte("dout #0BBE", exp_page.peff7, rd_byte);
		write_7ffd(8'($urandom) & 8'hDF);
		check_config();
		write_7ffd(8'($urandom) | 8'h20);
		check_config();
		write_7ffd(8'($urandom));             // this one sets the lock
		check_config();
		d = exp_page.p7ffd;
		write_7ffd(~d);
		check_config();
		check_byte("page.p7ffd while locked", d, page.p7ffd);

		// extension registers
		for (int i = 0; i < 16; i++)
		begin
			case ($urandom % 7)
				0:       idx = 8'h20;
				1:       idx = 8'h21;
				2:       idx = 8'h25;
				3:       idx = 8'h10;
				4:       idx = 8'h11;
				5:       idx = 8'h12;
				default: idx = 8'h13;
			endcase
			xt_write(idx, 8'($urandom));
			check_config();
		end
		for (int i = 0; i < 7; i++)
		begin
			xt_write(BAD_IDX[i], 8'($urandom));
			check_config();
		end
		io_read(16'h00AF);
		check_byte("dout #00AF", 8'h00, rd_byte);

		////////////////////////////////////////////////////////////////
		// IDE, Nemo order then divIDE order
		////////////////////////////////////////////////////////////////

		d  = 8'($urandom);
		d2 = 8'($urandom);
		io_write(16'h0011, d);
		check_bit("ide.wr_n pulse on #11", 1'b0, dev_wr_seen);
		check_bit("ide.dataout on #11", 1'b0, drv_seen);
		io_write(16'h0010, d2);
		check_bit("ide.wr_n pulse on #10", 1'b1, dev_wr_seen);
		check_bit("ide.dataout on #10", 1'b1, drv_seen);
		check_word("ide.wdata", {d, d2}, wdata_s);
		w     = 16'($urandom);
		idein = w;
		io_read(16'h0010);
		check_byte("dout #10", w[7:0], rd_byte);
		check_bit("ide.rd_n pulse on #10", 1'b1, dev_rd_seen);
		idein = ~w;                            // latched high byte must win
		io_read(16'h0011);
		check_byte("dout #11", w[15:8], rd_byte);
		check_bit("ide.rd_n pulse on #11", 1'b0, dev_rd_seen);

		w     = 16'($urandom);
		idein = w;
		io_read(16'h0010);
		check_byte("dout first #10", w[7:0], rd_byte);
		check_bit("ide.rd_n pulse on first #10", 1'b1, dev_rd_seen);
		idein = ~w;
		io_read(16'h0010);
		check_byte("dout second #10", w[15:8], rd_byte);
		check_bit("ide.rd_n pulse on second #10", 1'b0, dev_rd_seen);
		d  = 8'($urandom);
		d2 = 8'($urandom);
		io_write(16'h0010, d);
		check_bit("ide.wr_n pulse on first #10", 1'b0, dev_wr_seen);
		check_bit("ide.dataout on first #10", 1'b0, drv_seen);
		io_write(16'h0010, d2);
		check_bit("ide.wr_n pulse on second #10", 1'b1, dev_wr_seen);
		check_bit("ide.dataout on second #10", 1'b1, drv_seen);
		check_word("ide.wdata", {d2, d}, wdata_s);

		// chip selects and register address
		io_read(16'h00C8);
		check_bit("ide.cs1_n low on #C8", 1'b1, cs1_seen);
		check_bit("ide.cs0_n low on #C8", 1'b0, cs0_seen);
		check_byte("ide.a on #C8", 8'h06, {5'b00000, ide_a_s});
		io_read(16'h0030);
		check_bit("ide.cs0_n low on #30", 1'b1, cs0_seen);
		check_bit("ide.cs1_n low on #30", 1'b0, cs1_seen);
		check_byte("ide.a on #30", 8'h01, {5'b00000, ide_a_s});

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: verilog/zport_bus_sync.sv
//////////////////////////////////////////////////////////////////////
// samples the Z80 iorq/rd/wr levels on zclk and makes one-cycle
// read and write strobes per I/O bus cycle
//////////////////////////////////////////////////////////////////////

module zport_bus_sync import zport_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	output io_strobe_t io
);

	logic rd_lvl;
	logic wr_lvl;
	logic rd_q;
	logic wr_q;
	logic rd_stb;
	logic wr_stb;

	assign rd_lvl = ~(iorq_n | rd_n);
	assign wr_lvl = ~(iorq_n | wr_n);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			rd_q   <= 1'b0;
			wr_q   <= 1'b0;
			rd_stb <= 1'b0;
			wr_stb <= 1'b0;
		end
		else
		begin
			rd_q   <= rd_lvl;
			wr_q   <= wr_lvl;
			rd_stb <= rd_lvl & ~rd_q;    // first sampled edge only
			wr_stb <= wr_lvl & ~wr_q;
		end
	end

	assign io.wr     = wr_stb;
	assign io.rd     = rd_stb;
	assign io.wr_lvl = wr_lvl;
	assign io.rd_lvl = rd_lvl;

	a_no_rdwr: assert property (@(posedge zclk) disable iff (!rst_n) !(rd_stb && wr_stb));

endmodule

// File: verilog/zport_decode.sv
//////////////////////////////////////////////////////////////////////
// port decode and read data multiplexer; porthit and dataout go
// to the board bus buffers, sel goes to the register blocks
//////////////////////////////////////////////////////////////////////

module zport_decode import zport_pkg::*;
(
	input  zport_addr_u a,
	input  io_strobe_t  io,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [7:0]  ide_rdata,
	input  page_cfg_t   page,
	output port_sel_t   sel,
	output logic        porthit,
	output logic        dataout,
	output logic [7:0]  dout
);

	logic [7:0] lo;
	logic [7:0] hi;
	logic       fe_hit;
	logic       cs0_hit;

	assign lo = a.xt.port;
	assign hi = a.xt.idx;

	always_comb
	begin
		cs0_hit = 1'b0;
		for (int i = 0; i < $size(IDE_CS0); i++)
		begin
			if (lo == IDE_CS0[i])
				cs0_hit = 1'b1;
		end
	end

	assign fe_hit      = (lo == PORT_FE);
	assign sel.fd      = (lo == PORT_FD) && !hi[7];    // a15 low, #7FFD family
	assign sel.f7      = (lo == PORT_F7);
	assign sel.xt      = (lo == PORT_XT);
	assign sel.be      = (lo == PORT_BE);
	assign sel.ide_lo  = (lo == IDE_LO);
	assign sel.ide_hi  = (lo == IDE_HI);
	assign sel.ide_dev = sel.ide_lo || cs0_hit || (lo == IDE_CS1);

	assign porthit = fe_hit || sel.fd || sel.f7 || sel.xt || sel.be ||
	                 sel.ide_dev || sel.ide_hi;

	assign dataout = porthit & io.rd_lvl;

	////////////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (fe_hit)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.ide_dev || sel.ide_hi)
			dout = ide_rdata;
		else if (sel.be)
		begin
			case (hi[3:0])    // config read-back
				4'hA:    dout = page.p7ffd;
				4'hB:    dout = page.peff7;
				default: dout = 8'hFF;
			endcase
		end
		else if (sel.xt && (hi == XT_STATUS))
			dout = 8'h00;    // status, nothing busy
		else
			dout = 8'hFF;
	end

endmodule

// File: verilog/zport_ide_seq.sv
//////////////////////////////////////////////////////////////////////
// 16-bit IDE bridge for 8-bit Z80 accesses; handles both the Nemo
// (#10/#11) and the divIDE (#10/#10) byte order
//////////////////////////////////////////////////////////////////////

module zport_ide_seq import zport_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  zport_addr_u a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  io_strobe_t  io,
	input  port_sel_t   sel,
	input  logic [15:0] idein,
	output logic [7:0]  ide_rdata,
	output ide_bus_t    ide
);

	// normal read #10,#11   divide read #10,#10
	// normal write #11,#10  divide write #10,#10
	typedef enum logic [1:0] {
		IDLE,
		RD_HI_PENDING,    // low byte read, high byte held in hi_buf
		WR_LO_PENDING,    // high byte pre-written
		WR_HI_PENDING     // low byte pre-written (divide)
	} ide_state_e;

	ide_state_e  state;
	ide_state_e  rd_st_l;
	ide_state_e  wr_st_l;
	logic        ide_stb;
	logic        is_cs1;
	logic        rd_hi_l;
	logic        wr_lo_l;
	logic        wr_hi_l;
	logic        dev_rd_n;
	logic        dev_wr_n;
	logic [15:0] wr_buf;
	logic [7:0]  hi_buf;

	assign ide_stb = (io.rd | io.wr) & (sel.ide_dev | sel.ide_hi);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			state <= IDLE;
		else if (ide_stb)
		begin
			if (io.rd && sel.ide_lo && (state != RD_HI_PENDING))
				state <= RD_HI_PENDING;
			else if (io.wr && sel.ide_hi)
				state <= WR_LO_PENDING;
			else if (io.wr && sel.ide_lo && (state == IDLE))
				state <= WR_HI_PENDING;
			else
				state <= IDLE;    // pair done or broken
		end
	end

	always_ff @(posedge zclk)
	begin
		if (io.wr && sel.ide_hi)
			wr_buf[15:8] <= din;
		if (io.wr && sel.ide_lo && (state != WR_HI_PENDING))
			wr_buf[7:0] <= din;
		if (io.rd && sel.ide_lo && (state != RD_HI_PENDING))
			hi_buf <= idein[15:8];
	end

	// state seen by the current cycle, frozen while its strobe moves state
	always_latch
	begin
		if (rd_n)
			rd_st_l <= state;
	end

	always_latch
	begin
		if (wr_n)
			wr_st_l <= state;
	end

	assign rd_hi_l = (rd_st_l == RD_HI_PENDING);
	assign wr_lo_l = (wr_st_l == WR_LO_PENDING);
	assign wr_hi_l = (wr_st_l == WR_HI_PENDING);

	////////////////////////////////////////////////////////////////////
	// device side
	////////////////////////////////////////////////////////////////////

	assign is_cs1 = ({a.ide.ide_reg, a.ide.ide_low} == IDE_CS1);

	assign dev_rd_n = iorq_n | rd_n | ~sel.ide_dev | (rd_hi_l & sel.ide_lo);
	assign dev_wr_n = iorq_n | wr_n | ~sel.ide_dev | (sel.ide_lo & ~wr_lo_l & ~wr_hi_l);

	assign ide.a       = a.ide.ide_reg;
	assign ide.cs0_n   = ~(sel.ide_dev & ~is_cs1 & ~iorq_n);
	assign ide.cs1_n   = ~(sel.ide_dev & is_cs1 & ~iorq_n);
	assign ide.rd_n    = dev_rd_n;
	assign ide.wr_n    = dev_wr_n;
	assign ide.dataout = ~dev_wr_n;
	assign ide.wdata   = {wr_lo_l ? wr_buf[15:8] : din, wr_hi_l ? wr_buf[7:0] : din};

	assign ide_rdata = (sel.ide_hi || (rd_hi_l && sel.ide_lo)) ? hi_buf : idein[7:0];

	// latch must hold the state that the strobe acts on
	a_latch_state: assert property (@(posedge zclk) disable iff (!rst_n)
		ide_stb |-> ((io.rd ? rd_st_l : wr_st_l) == state));

endmodule

// File: verilog/zport_paging.sv
//////////////////////////////////////////////////////////////////////
// 128K/1M paging, ports #7FFD and #EFF7 with the 7FFD lock
//////////////////////////////////////////////////////////////////////

module zport_paging import zport_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  zport_addr_u a,
	input  logic [7:0]  din,
	input  io_strobe_t  io,
	input  port_sel_t   sel,
	output page_cfg_t   page
);

	logic [7:0] p7ffd;
	logic [7:0] peff7_q;
	logic [5:0] page_q;
	logic       rom_q;
	logic       lock;
	logic       block1m;
	logic       p7ffd_wr;
	logic       peff7_wr;

	assign block1m  = peff7_q[2];
	assign p7ffd_wr = io.wr && sel.fd && !lock;
	assign peff7_wr = io.wr && sel.f7 && !a.xt.idx[4] && a.xt.idx[0];    // a12=0, a8=1

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd  <= 8'h00;
			page_q <= 6'd0;
			rom_q  <= 1'b0;
			lock   <= 1'b0;
		end
		else if (p7ffd_wr)
		begin
			p7ffd  <= din;
			page_q <= {block1m ? 3'b000 : {din[5], din[7:6]}, din[2:0]};
			rom_q  <= din[4];
			lock   <= p7ffd[5] & block1m;    // 48K lock, only in 128K mode
		end
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			peff7_q <= 8'h00;
		else if (peff7_wr)
			peff7_q <= din;    // 2 block1m, 3 ram0 at #0000
	end

	assign page.page     = page_q;
	assign page.rom      = rom_q;
	assign page.mem1m_on = ~peff7_q[2];
	assign page.ram0_0   = peff7_q[3];
	assign page.peff7    = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;
	assign page.p7ffd    = p7ffd;

	// din still valid when the register takes it
	a_wr_in_cycle: assert property (@(posedge zclk) disable iff (!rst_n)
		(p7ffd_wr || peff7_wr) |-> io.wr_lvl);

endmodule

// File: verilog/zport_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared port numbers, register indexes and bus types for the Z80
// I/O port block, imported by every design module
//////////////////////////////////////////////////////////////////////

package zport_pkg;

	// low address byte of the ports
	localparam logic [7:0] PORT_FE = 8'hFE;
	localparam logic [7:0] PORT_FD = 8'hFD;
	localparam logic [7:0] PORT_F7 = 8'hF7;
	localparam logic [7:0] PORT_XT = 8'hAF;
	localparam logic [7:0] PORT_BE = 8'hBE;
	localparam logic [7:0] IDE_LO  = 8'h10;    // data, low byte
	localparam logic [7:0] IDE_HI  = 8'h11;    // data, high byte (never reaches the device)
	localparam logic [7:0] IDE_CS1 = 8'hC8;    // control block

	// rest of the task file, on cs0
	localparam logic [6:0][7:0] IDE_CS0 = {8'hF0, 8'hD0, 8'hB0, 8'h90, 8'h70, 8'h50, 8'h30};

	// #nnAF register indexes, high address byte
	localparam logic [7:0] XT_STATUS  = 8'h00;
	localparam logic [7:0] XT_RAMPAGE = 8'h10;  // #10..#13
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;

	localparam int DEF_RAMPAGES = 4;
	localparam logic [DEF_RAMPAGES-1:0][7:0] RAMPAGE_RST = {8'h00, 8'h02, 8'h05, 8'h00};

	typedef struct packed {
		logic [7:0] idx;       // extension register index
		logic [7:0] port;
	} addr_xt_t;

	typedef struct packed {
		logic [7:0] high;
		logic [2:0] ide_reg;   // a[7:5] to the device
		logic [4:0] ide_low;
	} addr_ide_t;

	typedef union packed {
		addr_xt_t  xt;
		addr_ide_t ide;
	} zport_addr_u;

	typedef struct packed {
		logic wr;              // one-cycle strobes
		logic rd;
		logic wr_lvl;          // raw bus cycle levels
		logic rd_lvl;
	} io_strobe_t;

	typedef struct packed {
		logic fd;
		logic f7;
		logic xt;
		logic be;
		logic ide_dev;         // task file port, goes out to the drive
		logic ide_lo;
		logic ide_hi;
	} port_sel_t;

	typedef struct packed {
		logic [5:0] page;
		logic       rom;
		logic       mem1m_on;
		logic       ram0_0;
		logic [7:0] peff7;
		logic [7:0] p7ffd;
	} page_cfg_t;

	typedef struct packed {
		logic [7:0]                   sysconf;
		logic [7:0]                   memconf;
		logic [7:0]                   im2vect;
		logic [DEF_RAMPAGES-1:0][7:0] rampage;
	} xt_cfg_t;

	typedef struct packed {
		logic [2:0]  a;
		logic        cs0_n;
		logic        cs1_n;
		logic        rd_n;
		logic        wr_n;
		logic        dataout;  // drive wdata onto the IDE bus
		logic [15:0] wdata;
	} ide_bus_t;

endpackage

// File: verilog/zport_top.sv
//////////////////////////////////////////////////////////////////////
// Z80 I/O port block top level; instance this on the board side of
// the Z80 bus, all logic runs on zclk
//////////////////////////////////////////////////////////////////////

module zport_top import zport_pkg::*;
#(
	parameter int NUM_RAMPAGES = 4
)
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [7:0]  din,
	input  zport_addr_u a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [15:0] idein,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output ide_bus_t    ide,
	output page_cfg_t   page,
	output xt_cfg_t     xt
);

	io_strobe_t io;
	port_sel_t  sel;
	logic [7:0] ide_rdata;

	zport_bus_sync u_bus_sync (.zclk(zclk), .rst_n(rst_n), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .io(io));

	zport_decode u_decode (.a(a), .io(io), .keys_in(keys_in), .tape_read(tape_read),
		.ide_rdata(ide_rdata), .page(page), .sel(sel), .porthit(porthit),
		.dataout(dataout), .dout(dout));

	zport_ide_seq u_ide_seq (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .io(io), .sel(sel), .idein(idein),
		.ide_rdata(ide_rdata), .ide(ide));

	zport_paging u_paging (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .io(io),
		.sel(sel), .page(page));

	zport_xt_regs #(.NUM_RAMPAGES(NUM_RAMPAGES)) u_xt_regs (.zclk(zclk), .rst_n(rst_n),
		.a(a), .din(din), .io(io), .sel(sel), .xt(xt));

endmodule

// File: verilog/zport_xt_regs.sv
//////////////////////////////////////////////////////////////////////
// extension port #nnAF configuration registers; the high address
// byte picks the register on each write
//////////////////////////////////////////////////////////////////////

module zport_xt_regs import zport_pkg::*;
#(
	parameter int NUM_RAMPAGES = 4
)
(
	input  logic        zclk,
	input  logic        rst_n,
	input  zport_addr_u a,
	input  logic [7:0]  din,
	input  io_strobe_t  io,
	input  port_sel_t   sel,
	output xt_cfg_t     xt
);

	logic [7:0]                   idx;
	logic                         xt_wr;
	logic                         rp_hit;
	logic [7:0]                   sysconf;
	logic [7:0]                   memconf;
	logic [7:0]                   im2vect;
	logic [DEF_RAMPAGES-1:0][7:0] rampage;

	assign idx    = a.xt.idx;
	assign xt_wr  = io.wr && sel.xt;
	assign rp_hit = (idx[7:2] == XT_RAMPAGE[7:2]);    // #10..#13

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			sysconf <= 8'h00;
			memconf <= 8'h00;
			im2vect <= 8'hFF;
		end
		else if (xt_wr)
		begin
			if (idx == XT_SYSCONF)
				sysconf <= din;
			if (idx == XT_MEMCONF)
				memconf <= din;
			if (idx == XT_IM2VECT)
				im2vect <= din;
		end
	end

	////////////////////////////////////////////////////////////////////
	// ram page windows
	////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < DEF_RAMPAGES; i++)
	begin : g_rampage
		if (i < NUM_RAMPAGES)
		begin : g_reg
			logic [7:0] rp_q;

			always_ff @(posedge zclk)
			begin
				if (!rst_n)
					rp_q <= RAMPAGE_RST[i];
				else if (xt_wr && rp_hit && (idx[1:0] == 2'(i)))
					rp_q <= din;
			end

			assign rampage[i] = rp_q;
		end
		else
		begin : g_none
			assign rampage[i] = 8'h00;    // window not built
		end
	end

	assign xt.sysconf = sysconf;
	assign xt.memconf = memconf;
	assign xt.im2vect = im2vect;
	assign xt.rampage = rampage;

endmodule
